// File: logic/aes_key_pkg.sv
package aes_key_pkg;

    // ====================
    // Sizes
    // ====================

    localparam int WORD_BITS = 32;
    localparam int ROUND_WORDS = 4;
    localparam int KEY_WORDS = 8;
    localparam int NUM_ROUND_KEYS = 15;
    localparam int SUB_CYCLES = 4;
    localparam logic [7:0] RCON_INIT = 8'h01;

    // Big-endian: the first byte or word sits in the top bits.
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ROUND_WORDS*WORD_BITS-1:0] round_key_t;
    typedef logic [KEY_WORDS*WORD_BITS-1:0] cipher_key_t;
    typedef logic [3:0] round_idx_t;
    typedef logic [$clog2(SUB_CYCLES)-1:0] sub_cnt_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_HIGH,
        LOAD_LOW,
        SUBSTITUTE,
        COMBINE
    } ctrl_state_t;

    // ====================
    // Forward S-box
    // ====================

    localparam logic [7:0] SBOX [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

endpackage

// File: logic/word_transform.sv
`timescale 1ns/1ps

module word_transform (
    input  logic                clk,
    input  logic                rst,
    input  logic                capture,
    input  logic                rotate,
    input  logic                shift,
    input  aes_key_pkg::word_t  word_in,
    input  logic [7:0]          rcon,
    output aes_key_pkg::word_t  temp_word
);
    import aes_key_pkg::*;

    word_t      sub_q;
    word_t      rot_word;
    logic [7:0] sub_byte;

    // RotWord moves the first byte to the end.
    assign rot_word = {word_in[23:0], word_in[31:24]};

    // One table lookup per cycle, always on the top byte.
    assign sub_byte = SBOX[sub_q[31:24]];

    // ====================
    // Byte register
    // ====================

    // Each shift substitutes the top byte and rotates it to the bottom,
    // so four shifts leave every byte substituted and back in place.
    always_ff @(posedge clk) begin
        if (rst) begin
            sub_q <= '0;
        end else if (capture) begin
            if (rotate) begin
                sub_q <= rot_word;
            end else begin
                sub_q <= word_in;
            end
        end else if (shift) begin
            sub_q <= {sub_q[23:0], sub_byte};
        end
    end

    // Round constant goes into the first byte only.
    assign temp_word = {sub_q[31:24] ^ rcon, sub_q[23:0]};

endmodule

// File: logic/key_window.sv
`timescale 1ns/1ps

module key_window (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  logic                     emit_high,
    input  logic                     emit_low,
    input  logic                     advance,
    input  aes_key_pkg::cipher_key_t key,
    input  aes_key_pkg::word_t       temp_word,
    output aes_key_pkg::word_t       last_word,
    output aes_key_pkg::round_key_t  round_key
);
    import aes_key_pkg::*;

    // Entry 0 is the oldest word, entry 7 the newest.
    word_t      win_q [KEY_WORDS];
    word_t      next_w [ROUND_WORDS];
    round_key_t high_key;
    round_key_t low_key;
    round_key_t next_key;

    // ====================
    // XOR chain
    // ====================

    always_comb begin
        next_w[0] = win_q[0] ^ temp_word;
        for (int i = 1; i < ROUND_WORDS; i++) begin
            next_w[i] = win_q[i] ^ next_w[i-1];
        end
        for (int i = 0; i < ROUND_WORDS; i++) begin
            high_key[(ROUND_WORDS-1-i)*WORD_BITS +: WORD_BITS] = win_q[i];
            low_key[(ROUND_WORDS-1-i)*WORD_BITS +: WORD_BITS]  = win_q[ROUND_WORDS+i];
            next_key[(ROUND_WORDS-1-i)*WORD_BITS +: WORD_BITS] = next_w[i];
        end
    end

    // Forwarded during advance so the next group can capture it on the same edge.
    assign last_word = advance ? next_w[ROUND_WORDS-1] : win_q[KEY_WORDS-1];

    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < KEY_WORDS; i++) begin
                win_q[i] <= key[(KEY_WORDS-1-i)*WORD_BITS +: WORD_BITS];
            end
        end else if (advance) begin
            for (int i = 0; i < ROUND_WORDS; i++) begin
                win_q[i]             <= win_q[ROUND_WORDS+i];
                win_q[ROUND_WORDS+i] <= next_w[i];
            end
        end
    end

    // Round key output, held until the next emit.
    always_ff @(posedge clk) begin
        if (rst) begin
            round_key <= '0;
        end else if (emit_high) begin
            round_key <= high_key;
        end else if (emit_low) begin
            round_key <= low_key;
        end else if (advance) begin
            round_key <= next_key;
        end
    end

endmodule

// File: logic/key_schedule_ctrl.sv
`timescale 1ns/1ps

module key_schedule_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    output logic                    load,
    output logic                    emit_high,
    output logic                    emit_low,
    output logic                    advance,
    output logic                    capture,
    output logic                    rotate,
    output logic                    shift,
    output logic [7:0]              rcon,
    output logic                    round_key_valid,
    output logic                    busy,
    output logic                    done,
    output aes_key_pkg::round_idx_t round_index
);
    import aes_key_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    sub_cnt_t    sub_cnt_q;
    round_idx_t  next_idx_q;
    logic        rot_group_q;
    logic [7:0]  rcon_q;
    logic        accept;
    logic        last_group;
    logic        emit_any;

    // GF(2^8) doubling with the AES polynomial.
    function automatic logic [7:0] xtime(input logic [7:0] b);
        logic [7:0] r;
        r = {b[6:0], 1'b0};
        if (b[7]) begin
            r = r ^ 8'h1b;
        end
        return r;
    endfunction

    assign accept     = (state_q == IDLE) && start && !busy;
    assign last_group = next_idx_q == round_idx_t'(NUM_ROUND_KEYS - 1);

    // ====================
    // Command decode
    // ====================

    assign load      = accept;
    assign emit_high = state_q == LOAD_HIGH;
    assign emit_low  = state_q == LOAD_LOW;
    assign advance   = state_q == COMBINE;
    assign shift     = state_q == SUBSTITUTE;
    assign emit_any  = emit_high || emit_low || advance;

    // Next group's word is captured while the current group combines.
    assign capture = emit_low || (advance && !last_group);

    // rot_group_q marks the group in flight; rotate applies to the one captured next.
    assign rotate = !rot_group_q;
    assign rcon   = rot_group_q ? rcon_q : 8'h00;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LOAD_HIGH;
                end
            end
            LOAD_HIGH: state_d = LOAD_LOW;
            LOAD_LOW: state_d = SUBSTITUTE;
            SUBSTITUTE: begin
                if (sub_cnt_q == sub_cnt_t'(SUB_CYCLES - 1)) begin
                    state_d = COMBINE;
                end
            end
            COMBINE: state_d = last_group ? IDLE : SUBSTITUTE;
            default: state_d = IDLE;
        endcase
    end

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q         <= IDLE;
            sub_cnt_q       <= '0;
            next_idx_q      <= '0;
            rot_group_q     <= 1'b0;
            rcon_q          <= RCON_INIT;
            busy            <= 1'b0;
            done            <= 1'b0;
            round_key_valid <= 1'b0;
            round_index     <= '0;
        end else begin
            state_q         <= state_d;
            round_key_valid <= emit_any;
            done            <= advance && last_group;

            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end

            // Wraps to zero as SUBSTITUTE ends.
            if (shift) begin
                sub_cnt_q <= sub_cnt_q + 1'b1;
            end

            if (accept) begin
                next_idx_q  <= '0;
                sub_cnt_q   <= '0;
                rot_group_q <= 1'b0;
                rcon_q      <= RCON_INIT;
            end

            if (emit_any) begin
                round_index <= next_idx_q;
                next_idx_q  <= next_idx_q + 1'b1;
            end

            // First group after the key is a rotated one.
            if (emit_low) begin
                rot_group_q <= 1'b1;
            end

            if (advance) begin
                rot_group_q <= !rot_group_q;
                if (rot_group_q) begin
                    rcon_q <= xtime(rcon_q);
                end
            end
        end
    end

endmodule

// File: logic/key_expansion_top.sv
`timescale 1ns/1ps

module key_expansion_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  aes_key_pkg::cipher_key_t key,
    output aes_key_pkg::round_key_t  round_key,
    output logic                     round_key_valid,
    output logic                     busy,
    output logic                     done,
    output aes_key_pkg::round_idx_t  round_index
);
    import aes_key_pkg::*;

    logic       load;
    logic       emit_high;
    logic       emit_low;
    logic       advance;
    logic       capture;
    logic       rotate;
    logic       shift;
    logic [7:0] rcon;
    word_t      last_word;
    word_t      temp_word;

    // ====================
    // Sequencer
    // ====================

    key_schedule_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .load            (load),
        .emit_high       (emit_high),
        .emit_low        (emit_low),
        .advance         (advance),
        .capture         (capture),
        .rotate          (rotate),
        .shift           (shift),
        .rcon            (rcon),
        .round_key_valid (round_key_valid),
        .busy            (busy),
        .done            (done),
        .round_index     (round_index)
    );

    // ====================
    // Datapath
    // ====================

    key_window u_window (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .emit_high (emit_high),
        .emit_low  (emit_low),
        .advance   (advance),
        .key       (key),
        .temp_word (temp_word),
        .last_word (last_word),
        .round_key (round_key)
    );

    word_transform u_transform (
        .clk       (clk),
        .rst       (rst),
        .capture   (capture),
        .rotate    (rotate),
        .shift     (shift),
        .word_in   (last_word),
        .rcon      (rcon),
        .temp_word (temp_word)
    );

endmodule

// File: testbench/key_model.svh
`ifndef KEY_MODEL_SVH
`define KEY_MODEL_SVH

// Reference S-box, built at run time from the field inverse and the affine map.
logic [7:0] model_sbox [256];
round_key_t exp_keys [NUM_ROUND_KEYS];

// GF(2^8) product modulo x^8 + x^4 + x^3 + x + 1.
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            p = p ^ x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// Inverse as a^254, which also maps zero to zero.
function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] r;
    r = 8'h01;
    for (int i = 0; i < 254; i++) begin
        r = gf_mul(r, a);
    end
    return r;
endfunction

function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
    return (b << n) | (b >> (8 - n));
endfunction

task automatic build_model_sbox();
    logic [7:0] v;
    for (int x = 0; x < 256; x++) begin
        v = gf_inv(8'(x));
        model_sbox[x] = v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
    end
endtask

function automatic word_t sub_word(input word_t w);
    return {model_sbox[w[31:24]], model_sbox[w[23:16]], model_sbox[w[15:8]], model_sbox[w[7:0]]};
endfunction

// Full AES-256 schedule of 60 words, grouped into 15 round keys.
task automatic compute_schedule(input cipher_key_t k);
    word_t      w [60];
    word_t      t;
    logic [7:0] rc;
    rc = 8'h01;
    for (int i = 0; i < 8; i++) begin
        w[i] = k[255 - 32*i -: 32];
    end
    for (int i = 8; i < 60; i++) begin
        t = w[i-1];
        if (i % 8 == 0) begin
            t  = sub_word({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
            rc = gf_mul(rc, 8'h02);
        end else if (i % 8 == 4) begin
            t = sub_word(t);
        end
        w[i] = w[i-8] ^ t;
    end
    for (int r = 0; r < NUM_ROUND_KEYS; r++) begin
        exp_keys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
endtask

`endif

// File: testbench/tb_key_expansion.sv
`timescale 1ns/1ps

module tb_key_expansion;
    import aes_key_pkg::*;

    localparam int unsigned SEED = 32'hc522_cce3;
    localparam int LAST_EDGE = 67;
    localparam int TIMEOUT = 200;
    localparam round_key_t STD_KEY14 = 128'h24fc79ccbf0979e9371ac23c6d68de36;

    logic        clk;
    logic        rst;
    logic        start;
    cipher_key_t key;
    round_key_t  round_key;
    logic        round_key_valid;
    logic        busy;
    logic        done;
    round_idx_t  round_index;

    int errors = 0;
    int timeouts = 0;
    int edge_cnt = -1;
    int pulses = 0;

    `include "key_model.svh"

    key_expansion_top dut (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .key             (key),
        .round_key       (round_key),
        .round_key_valid (round_key_valid),
        .busy            (busy),
        .done            (done),
        .round_index     (round_index)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic value_error(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        errors++;
        $display("ERROR t=%0t %s expected=%h got=%h", $time, name, expected, actual);
    endtask

    // ====================
    // Timing reference
    // ====================

    // True from the accepting edge up to the edge that ends the run.
    function automatic bit run_active(input int k);
        return k >= 0 && k <= LAST_EDGE;
    endfunction

    // Edges since the accepted start. Stays at -1 after reset until a start is taken.
    always @(posedge clk) begin
        if (rst) begin
            edge_cnt <= -1;
        end else if (start && !run_active(edge_cnt)) begin
            edge_cnt <= 0;
        end else if (edge_cnt >= 0) begin
            edge_cnt <= edge_cnt + 1;
        end
        if (rst || (start && !run_active(edge_cnt))) begin
            pulses <= 0;
        end else if (round_key_valid) begin
            pulses <= pulses + 1;
        end
    end

    // True when a round key is due right after edge k.
    function automatic bit key_due(input int k);
        return k == 1 || k == 2 || (k >= 7 && k <= LAST_EDGE && (k + 3) % 5 == 0);
    endfunction

    function automatic int due_index(input int k);
        if (k <= 2) begin
            return k - 1;
        end
        return (k + 3) / 5;
    endfunction

    // ====================
    // Assertions
    // ====================

    valid_timing_check: assert property (@(posedge clk) disable iff (rst)
        round_key_valid == key_due(edge_cnt))
        else value_error("round_key_valid", 128'(key_due($sampled(edge_cnt))),
                         128'($sampled(round_key_valid)));

    index_check: assert property (@(posedge clk) disable iff (rst)
        round_key_valid |-> round_index == round_idx_t'(due_index(edge_cnt)))
        else value_error("round_index", 128'(due_index($sampled(edge_cnt))),
                         128'($sampled(round_index)));

    key_check: assert property (@(posedge clk) disable iff (rst)
        (round_key_valid && key_due(edge_cnt)) |-> round_key == exp_keys[due_index(edge_cnt)])
        else value_error("round_key", exp_keys[due_index($sampled(edge_cnt))],
                         $sampled(round_key));

    done_check: assert property (@(posedge clk) disable iff (rst)
        done == (edge_cnt == LAST_EDGE))
        else value_error("done", 128'($sampled(edge_cnt) == LAST_EDGE), 128'($sampled(done)));

    busy_check: assert property (@(posedge clk) disable iff (rst)
        busy == run_active(edge_cnt))
        else value_error("busy", 128'(run_active($sampled(edge_cnt))), 128'($sampled(busy)));

    // ====================
    // Stimulus
    // ====================

    task automatic begin_run(input cipher_key_t k);
        compute_schedule(k);
        key   = k;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout at %0t: no done pulse within %0d cycles", $time, TIMEOUT);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            timeouts++;
            $display("Timeout at %0t: busy stayed high for %0d cycles", $time, TIMEOUT);
        end
    endtask

    task automatic finish_run();
        wait_done();
        wait_idle();
        assert (pulses == NUM_ROUND_KEYS)
            else value_error("round_key_valid count", 128'(NUM_ROUND_KEYS), 128'(pulses));
    endtask

    task automatic run_key(input cipher_key_t k);
        begin_run(k);
        finish_run();
    endtask

    function automatic cipher_key_t random_key();
        cipher_key_t k;
        for (int j = 0; j < 8; j++) begin
            k[32*j +: 32] = $urandom;
        end
        return k;
    endfunction

    initial begin
        cipher_key_t k;
        void'($urandom(SEED));
        rst   = 1'b1;
        start = 1'b0;
        key   = '0;
        build_model_sbox();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        // Round key 14 stays on the output after the standard key run.
        run_key(256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f);
        assert (round_key == STD_KEY14)
            else value_error("round_key", STD_KEY14, round_key);

        for (int i = 0; i < 20; i++) begin
            run_key(random_key());
        end

        // A second start in mid-run must be ignored.
        begin_run(random_key());
        repeat (20) @(negedge clk);
        key   = random_key();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        finish_run();

        // Reset in mid-run followed by a quiet gap and a fresh run.
        begin_run(random_key());
        repeat (30) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        repeat (10) @(negedge clk);
        k = random_key();
        run_key(k);
        repeat (5) @(negedge clk);

        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+testbench
logic/aes_key_pkg.sv
logic/word_transform.sv
logic/key_window.sv
logic/key_schedule_ctrl.sv
logic/key_expansion_top.sv
testbench/tb_key_expansion.sv

// File: Makefile
# Verilator build and run of the key expansion testbench.

VERILATOR ?= verilator
TOP       ?= tb_key_expansion
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard logic/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
